// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  ////////////////////////////////////////////////////////////
  // Memory geometry
  ////////////////////////////////////////////////////////////

  localparam int MEM_DEPTH = 256;                 // Words in the RAM
  localparam int WORD_W    = 32;                  // Data width
  localparam int BYTE_W    = 8;                   // Lane width
  localparam int NB_BYTES  = WORD_W / BYTE_W;     // Byte lanes per word
  localparam int OFFSET_W  = $clog2(NB_BYTES);    // Byte offset inside a word
  localparam int INDEX_W   = $clog2(MEM_DEPTH);   // Word index
  localparam int ADDR_W    = OFFSET_W + INDEX_W;  // Full byte address

  ////////////////////////////////////////////////////////////
  // Request types
  ////////////////////////////////////////////////////////////

  // Access size as decoded from the load/store opcode
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_t;

  // One load or store request, valid for a single cycle
  typedef struct packed {
    logic              rd;           // Load strobe
    logic              wr;           // Store strobe
    mem_size_t         size;
    logic              unsigned_ld;  // LBU / LHU
    logic [ADDR_W-1:0] addr;         // Byte address
    logic [WORD_W-1:0] data;         // Store data, right aligned
  } mem_req_t;

  // Memory word seen whole or lane by lane
  typedef union packed {
    logic [WORD_W-1:0]               word;
    logic [NB_BYTES-1:0][BYTE_W-1:0] bytes;  // Lane 0 is the low byte
  } mem_word_t;

endpackage

`default_nettype wire

// ==== hw/access_aligner.sv ====
`default_nettype none

module access_aligner (
  input  mem_pkg::mem_req_t               i_req,
  output logic                            o_access,      // Read or write strobe seen
  output logic [mem_pkg::INDEX_W-1:0]     o_index,       // Word index into the RAM
  output logic [mem_pkg::NB_BYTES-1:0]    o_byte_en,     // Lanes to write
  output mem_pkg::mem_word_t              o_store_word,  // Store data moved to its lanes
  output logic                            o_misaligned
);
  import mem_pkg::*;

  logic [OFFSET_W-1:0] offset;
  logic [NB_BYTES-1:0] lane_mask;   // Lanes touched by this size and offset
  logic                is_req;
  logic                bad_align;

  assign offset   = i_req.addr[OFFSET_W-1:0];
  assign o_index  = i_req.addr[ADDR_W-1:OFFSET_W];
  assign is_req   = i_req.rd | i_req.wr;
  assign o_access = is_req;  // Misaligned ones too, so that the error gets reported

  // Alignment check and lane mask per size
  always_comb begin
    case (i_req.size)
      SIZE_BYTE: begin
        bad_align = 1'b0;                                         // Any offset is fine
        lane_mask = {{(NB_BYTES-1){1'b0}}, 1'b1} << offset;
      end
      SIZE_HALF: begin
        bad_align = offset[0];                                    // Must sit on an even byte
        lane_mask = {{(NB_BYTES-2){1'b0}}, 2'b11} << offset;
      end
      default: begin
        bad_align = |offset;                                      // Word needs offset 0
        lane_mask = '1;
      end
    endcase
  end

  // Store data placement with the byte view
  always_comb begin
    o_store_word = '0;
    case (i_req.size)
      SIZE_BYTE: o_store_word.bytes[offset] = i_req.data[BYTE_W-1:0];
      SIZE_HALF: begin
        // Low half to lanes 0/1, high half to lanes 2/3
        o_store_word.bytes[{offset[OFFSET_W-1], 1'b0}] = i_req.data[BYTE_W-1:0];
        o_store_word.bytes[{offset[OFFSET_W-1], 1'b1}] = i_req.data[2*BYTE_W-1:BYTE_W];
      end
      default: o_store_word.word = i_req.data;
    endcase
  end

  // Only aligned stores write anything
  assign o_byte_en    = (i_req.wr && !bad_align) ? lane_mask : '0;
  assign o_misaligned = is_req & bad_align;

endmodule

`default_nettype wire

// ==== hw/data_memory.sv ====
`default_nettype none

module data_memory (
  input  logic                          i_clk,
  input  logic                          i_rsta,
  input  logic                          i_access,      // Request present this cycle
  input  logic [mem_pkg::INDEX_W-1:0]   i_index,
  input  logic [mem_pkg::NB_BYTES-1:0]  i_byte_en,
  input  mem_pkg::mem_word_t            i_store_word,
  input  logic                          i_clear,       // Start a sweep
  output mem_pkg::mem_word_t            o_read_word,   // Prior contents, one cycle later
  output logic                          o_accept,      // Pulse for an accepted request
  output logic                          o_clear_busy
);
  import mem_pkg::*;

  // Contents start at zero, reset leaves them alone
  mem_word_t            ram [MEM_DEPTH] = '{default: '0};

  logic [INDEX_W-1:0]   sweep_cnt;    // Word being cleared
  logic                 busy;         // Sweep running
  logic                 sweep_last;
  logic                 accept;

  // Single port, shared by the sweep and by requests
  logic [INDEX_W-1:0]   port_index;
  logic [NB_BYTES-1:0]  port_we;
  mem_word_t            port_word;

  ////////////////////////////////////////////////////////////
  // Request gating
  ////////////////////////////////////////////////////////////

  // A clear in the same cycle wins, and nothing gets in during a sweep
  assign accept     = i_access & ~busy & ~i_clear;
  assign sweep_last = (sweep_cnt == INDEX_W'(MEM_DEPTH - 1));

  assign port_index = busy ? sweep_cnt : i_index;
  assign port_word  = busy ? '0 : i_store_word;  // Sweep writes zeros

  always_comb begin
    if (busy) begin
      port_we = '1;                // Whole word per sweep step
    end else if (accept) begin
      port_we = i_byte_en;         // Zero for loads and misaligned stores
    end else begin
      port_we = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sweep FSM and accept pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      busy      <= 1'b0;
      sweep_cnt <= '0;
      o_accept  <= 1'b0;
    end else begin
      o_accept <= accept;
      if (busy) begin
        sweep_cnt <= sweep_cnt + 1'b1;  // Wraps back to 0 after the last word
        if (sweep_last) begin
          busy <= 1'b0;
        end
      end else if (i_clear) begin
        busy      <= 1'b1;              // Clear while busy is ignored
        sweep_cnt <= '0;
      end
    end
  end

  assign o_clear_busy = busy;

  ////////////////////////////////////////////////////////////
  // Byte-write read-first RAM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_read_word <= ram[port_index];   // Old value, before this cycle's write
    end
    for (int b = 0; b < NB_BYTES; b++) begin
      if (port_we[b]) begin
        ram[port_index].bytes[b] <= port_word.bytes[b];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/load_extractor.sv ====
`default_nettype none

module load_extractor (
  input  logic                        i_clk,
  input  logic                        i_rsta,
  input  mem_pkg::mem_req_t           i_req,
  input  logic                        i_misaligned,
  input  mem_pkg::mem_word_t          i_read_word,   // RAM output, one cycle after i_req
  input  logic                        i_accept,
  output logic [mem_pkg::WORD_W-1:0]  o_load_data,
  output logic                        o_done,
  output logic                        o_addr_error
);
  import mem_pkg::*;

  // What the load needs once the RAM word comes back
  typedef struct packed {
    logic [OFFSET_W-1:0] offset;
    mem_size_t           size;
    logic                unsigned_ld;
    logic                rd;
    logic                misaligned;
  } load_ctx_t;

  load_ctx_t           ctx;
  logic [BYTE_W-1:0]   sel_byte;
  logic [2*BYTE_W-1:0] sel_half;
  logic                sign_fill;
  logic [WORD_W-1:0]   ext_data;

  // Context follows the request into the RAM stage
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      ctx <= '0;
    end else begin
      ctx.offset      <= i_req.addr[OFFSET_W-1:0];
      ctx.size        <= i_req.size;
      ctx.unsigned_ld <= i_req.unsigned_ld;
      ctx.rd          <= i_req.rd;
      ctx.misaligned  <= i_misaligned;
    end
  end

  // Lane select by stored offset, then sign or zero fill
  always_comb begin
    sel_byte = i_read_word.bytes[ctx.offset];
    sel_half = {i_read_word.bytes[{ctx.offset[OFFSET_W-1], 1'b1}],
                i_read_word.bytes[{ctx.offset[OFFSET_W-1], 1'b0}]};
    case (ctx.size)
      SIZE_BYTE: begin
        sign_fill = ~ctx.unsigned_ld & sel_byte[BYTE_W-1];
        ext_data  = {{(WORD_W-BYTE_W){sign_fill}}, sel_byte};
      end
      SIZE_HALF: begin
        sign_fill = ~ctx.unsigned_ld & sel_half[2*BYTE_W-1];
        ext_data  = {{(WORD_W-2*BYTE_W){sign_fill}}, sel_half};
      end
      default: begin
        sign_fill = 1'b0;                // Nothing to extend
        ext_data  = i_read_word.word;
      end
    endcase
  end

  assign o_done       = i_accept;
  assign o_addr_error = i_accept & ctx.misaligned;
  // Zero on stores, on errors and between accesses
  assign o_load_data  = (i_accept && ctx.rd && !ctx.misaligned) ? ext_data : '0;

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`default_nettype none

module mem_stage (
  input  logic                        i_clk,
  input  logic                        i_rsta,
  input  mem_pkg::mem_req_t           i_req,
  input  logic                        i_clear,       // One-cycle pulse, starts a sweep
  output logic [mem_pkg::WORD_W-1:0]  o_load_data,
  output logic                        o_done,
  output logic                        o_addr_error,
  output logic                        o_clear_busy
);
  import mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // Aligner to RAM
  ////////////////////////////////////////////////////////////

  logic                access;
  logic [INDEX_W-1:0]  index;
  logic [NB_BYTES-1:0] byte_en;
  mem_word_t           store_word;
  logic                misaligned;    // Also to the extractor

  // RAM to extractor
  mem_word_t           read_word;
  logic                accept;

  access_aligner access_aligner_i (
    .i_req        (i_req),
    .o_access     (access),
    .o_index      (index),
    .o_byte_en    (byte_en),
    .o_store_word (store_word),
    .o_misaligned (misaligned)
  );

  data_memory data_memory_i (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_access     (access),
    .i_index      (index),
    .i_byte_en    (byte_en),
    .i_store_word (store_word),
    .i_clear      (i_clear),
    .o_read_word  (read_word),
    .o_accept     (accept),
    .o_clear_busy (o_clear_busy)
  );

  load_extractor load_extractor_i (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_req        (i_req),
    .i_misaligned (misaligned),
    .i_read_word  (read_word),
    .i_accept     (accept),
    .o_load_data  (o_load_data),
    .o_done       (o_done),
    .o_addr_error (o_addr_error)
  );

endmodule

`default_nettype wire

// ==== sim/mem_stage_assertions.sv ====
`default_nettype none

module mem_stage_assertions (
  input logic                        i_clk,
  input logic                        i_rsta,
  input logic [mem_pkg::WORD_W-1:0]  i_load_data,
  input logic                        i_done,
  input logic                        i_addr_error,
  input logic                        i_clear_busy
);

  ////////////////////////////////////////////////////////////
  // Output protocol of the memory stage
  ////////////////////////////////////////////////////////////

  // Error pulse only rides on a done pulse
  err_with_done: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_addr_error |-> i_done)
    else $error("o_addr_error without o_done");

  // Failed access returns no data
  err_zero_data: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_addr_error |-> (i_load_data == '0))
    else $error("o_load_data not zero on o_addr_error");

  // Requests during a sweep are dropped
  no_done_after_busy: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_clear_busy |=> !i_done)
    else $error("o_done right after a busy cycle");

endmodule

bind mem_stage mem_stage_assertions mem_stage_assertions_i (
  .i_clk        (i_clk),
  .i_rsta       (i_rsta),
  .i_load_data  (o_load_data),
  .i_done       (o_done),
  .i_addr_error (o_addr_error),
  .i_clear_busy (o_clear_busy)
);

`default_nettype wire

// ==== sim/tb_mem_stage.sv ====
`default_nettype none

module tb_mem_stage;
  import mem_pkg::*;

  localparam int DONE_TIMEOUT = 16;      // Cycles to wait for o_done

  logic              i_clk;
  logic              i_rsta;
  mem_req_t          i_req;
  logic              i_clear;
  logic [WORD_W-1:0] o_load_data;
  logic              o_done;
  logic              o_addr_error;
  logic              o_clear_busy;

  mem_word_t         ref_mem [MEM_DEPTH];  // Expected RAM contents
  logic [31:0]       lcg_state = 32'h7e37;
  int                n_checks  = 0;
  int                n_errors  = 0;

  mem_stage mem_stage_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and reference helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits, aligned down to the access size
  function automatic logic [ADDR_W-1:0] rand_addr(mem_size_t size);
    logic [31:0] r;
    r = next_rand() >> 8;
    case (size)
      SIZE_BYTE: return r[ADDR_W-1:0];
      SIZE_HALF: return {r[ADDR_W-1:1], 1'b0};
      default:   return {r[ADDR_W-1:2], 2'b00};
    endcase
  endfunction

  function automatic mem_req_t make_req(logic rd, logic wr, mem_size_t size, logic uns,
                                        logic [ADDR_W-1:0] addr, logic [WORD_W-1:0] data);
    mem_req_t r;
    r.rd          = rd;
    r.wr          = wr;
    r.size        = size;
    r.unsigned_ld = uns;
    r.addr        = addr;
    r.data        = data;
    return r;
  endfunction

  // Store lands in the addressed lanes, the rest keep their bytes
  function automatic mem_word_t merge_store(mem_word_t old, logic [WORD_W-1:0] data,
                                            logic [1:0] off, mem_size_t size);
    logic [WORD_W-1:0] mask;
    mem_word_t         r;
    case (size)
      SIZE_BYTE: mask = 32'h0000_00ff;
      SIZE_HALF: mask = 32'h0000_ffff;
      default:   mask = '1;
    endcase
    mask   = mask << {off, 3'b000};
    r.word = (old.word & ~mask) | ((data << {off, 3'b000}) & mask);
    return r;
  endfunction

  // Shift the lane down, then sign or zero fill
  function automatic mem_word_t expect_load(mem_word_t w, logic [1:0] off, mem_size_t size,
                                            logic uns);
    logic [WORD_W-1:0] sh;
    mem_word_t         r;
    sh = w.word >> {off, 3'b000};
    case (size)
      SIZE_BYTE: r.word = {{(WORD_W-8){sh[7] & ~uns}}, sh[7:0]};
      SIZE_HALF: r.word = {{(WORD_W-16){sh[15] & ~uns}}, sh[15:0]};
      default:   r.word = w.word;
    endcase
    return r;
  endfunction

  task automatic check_word(mem_word_t got, mem_word_t exp, string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s got %h, expected %h", $time, what, got.word, exp.word);
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus tasks, entered and left 1 unit after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic do_access(input mem_req_t req, output mem_word_t data, output logic err);
    int lat;
    i_req = req;
    @(posedge i_clk); #1;
    i_req = '0;
    lat   = 1;
    while (!o_done && lat < DONE_TIMEOUT) begin
      @(posedge i_clk); #1;
      lat++;
    end
    if (!o_done) begin
      n_errors++;
      $display("Timeout: no o_done within %0d cycles of the request to %h", lat, req.addr);
    end else begin
      check_flag(logic'(lat == 1), 1'b1, $sformatf("o_done after %0d cycles", lat));
    end
    data.word = o_load_data;
    err       = o_addr_error;
  endtask

  task automatic store(mem_size_t size, logic [ADDR_W-1:0] addr, logic [WORD_W-1:0] data);
    mem_word_t d;
    logic      e;
    do_access(make_req(1'b0, 1'b1, size, 1'b0, addr, data), d, e);
    check_flag(e, 1'b0, $sformatf("o_addr_error on store @%h", addr));
    check_word(d, '0, $sformatf("o_load_data on store @%h", addr));
    ref_mem[addr[ADDR_W-1:2]] = merge_store(ref_mem[addr[ADDR_W-1:2]], data, addr[1:0], size);
  endtask

  task automatic load_check(mem_size_t size, logic uns, logic [ADDR_W-1:0] addr);
    mem_word_t d;
    logic      e;
    do_access(make_req(1'b1, 1'b0, size, uns, addr, next_rand()), d, e);
    check_flag(e, 1'b0, $sformatf("o_addr_error on load @%h", addr));
    check_word(d, expect_load(ref_mem[addr[ADDR_W-1:2]], addr[1:0], size, uns),
               $sformatf("load size %0d uns %b @%h", size, uns, addr));
  endtask

  // Must be flagged and must return zero data
  task automatic misaligned(logic rd, mem_size_t size, logic [ADDR_W-1:0] addr);
    mem_word_t d;
    logic      e;
    do_access(make_req(rd, ~rd, size, 1'b0, addr, next_rand()), d, e);
    check_flag(e, 1'b1, $sformatf("o_addr_error @%h", addr));
    check_word(d, '0, $sformatf("o_load_data on misaligned @%h", addr));
  endtask

  task automatic report(string name, int errs_before);
    $display("%-12s %s (%0d errors)", name,
             (n_errors == errs_before) ? "ok" : "failed", n_errors - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e0 = n_errors;
    check_flag(o_done, 1'b0, "o_done after reset");
    check_flag(o_addr_error, 1'b0, "o_addr_error after reset");
    check_flag(o_clear_busy, 1'b0, "o_clear_busy after reset");
    for (int i = 0; i < 8; i++) load_check(SIZE_WORD, 1'b0, rand_addr(SIZE_WORD));
    report("reset", e0);
  endtask

  task automatic test_word_rw();
    int                e0 = n_errors;
    logic [ADDR_W-1:0] addrs [8];
    for (int i = 0; i < 8; i++) begin
      addrs[i] = rand_addr(SIZE_WORD);
      store(SIZE_WORD, addrs[i], next_rand());
    end
    for (int i = 0; i < 8; i++) load_check(SIZE_WORD, 1'b0, addrs[i]);
    report("word_rw", e0);
  endtask

  task automatic test_sub_word();
    int                e0 = n_errors;
    mem_size_t         size;
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < 16; i++) begin
      size = i[0] ? SIZE_HALF : SIZE_BYTE;
      a    = rand_addr(size);
      store(size, a, next_rand());
      load_check(size, 1'b0, a);                              // Sign extended
      load_check(size, 1'b1, a);                              // Zero extended
      load_check(SIZE_WORD, 1'b0, {a[ADDR_W-1:2], 2'b00});   // Other lanes intact
    end
    report("sub_word", e0);
  endtask

  task automatic test_misaligned();
    int                e0 = n_errors;
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < 4; i++) begin
      a = rand_addr(SIZE_WORD);
      store(SIZE_WORD, a, next_rand());
      misaligned(1'b0, SIZE_HALF, {a[ADDR_W-1:2], i[0], 1'b1});
      misaligned(1'b0, SIZE_WORD, {a[ADDR_W-1:2], 2'(i % 3 + 1)});
      misaligned(1'b1, SIZE_HALF, {a[ADDR_W-1:2], i[1], 1'b1});
      load_check(SIZE_WORD, 1'b0, a);                         // Word must be unchanged
    end
    report("misaligned", e0);
  endtask

  task automatic test_clear();
    int e0     = n_errors;
    int cycles = 0;
    // Clear and a store in the same cycle, the clear wins
    i_clear = 1'b1;
    i_req   = make_req(1'b0, 1'b1, SIZE_WORD, 1'b0, rand_addr(SIZE_WORD), next_rand());
    @(posedge i_clk); #1;
    i_clear = 1'b0;
    i_req   = '0;
    check_flag(o_clear_busy, 1'b1, "o_clear_busy after i_clear");
    while (o_clear_busy && cycles < MEM_DEPTH + DONE_TIMEOUT) begin
      check_flag(o_done, 1'b0, "o_done during sweep");
      cycles++;
      // Words the sweep has passed already, last one in the final busy cycle
      if ((cycles >= 4 && cycles < 12) || cycles == MEM_DEPTH) begin
        i_req = make_req(cycles[0], ~cycles[0], SIZE_WORD, 1'b0,
                         {INDEX_W'(cycles - 4), 2'b00}, next_rand());
      end else begin
        i_req = '0;
      end
      i_clear = (cycles == 20);                              // Ignored while busy
      @(posedge i_clk); #1;
    end
    i_req   = '0;
    i_clear = 1'b0;
    if (o_clear_busy) begin
      n_errors++;
      $display("Timeout: o_clear_busy still high after %0d cycles", cycles);
    end
    check_flag(logic'(cycles == MEM_DEPTH), 1'b1,
               $sformatf("o_clear_busy high for %0d cycles", cycles));
    check_flag(o_done, 1'b0, "o_done after sweep");
    foreach (ref_mem[i]) ref_mem[i] = '0;
    for (int i = 0; i < MEM_DEPTH; i++) load_check(SIZE_WORD, 1'b0, {INDEX_W'(i), 2'b00});
    report("clear", e0);
  endtask

  initial begin
    i_rsta  = 1'b1;
    i_req   = '0;
    i_clear = 1'b0;
    foreach (ref_mem[i]) ref_mem[i] = '0;
    repeat (10) @(posedge i_clk);
    #1 i_rsta = 1'b0;
    test_reset();
    test_word_rw();
    test_sub_word();
    test_misaligned();
    test_clear();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/mem_pkg.sv
hw/access_aligner.sv
hw/data_memory.sv
hw/load_extractor.sv
hw/mem_stage.sv
sim/mem_stage_assertions.sv
sim/tb_mem_stage.sv

// ==== Makefile ====
SRCS := $(shell cat vlog.f)
BIN  := obj_dir/Vtb_mem_stage

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): vlog.f $(SRCS)
	verilator --binary --assert --top-module tb_mem_stage -f vlog.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log || grep -q "%Error" sim.log || \
	    ! grep -q "NO ERRORS" sim.log; then \
	  echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
